// File: Bender.yml
package:
  name: decode_stage

sources:
  - design/isa_pkg.sv
  - design/decode_ctrl_if.sv
  - design/decode_bundle_if.sv
  - design/control.sv
  - design/rf_bypassed.sv
  - design/decode.sv
  - design/id_ex_reg.sv
  - design/decode_top.sv
  - target: simulation
    files:
      - verification/decode_asserts.sv
      - verification/decode_tb.sv

// File: design/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
    input  isa_pkg::opcode_t opcode,
    input  isa_pkg::op_ext_t op_ext,
    decode_ctrl_if.ctrl      ctrl
);
    import isa_pkg::*;

    always_comb begin
        // everything idle unless the opcode says otherwise
        ctrl.instr_rformat = 1'b0;
        ctrl.writeto_rs    = 1'b0;
        ctrl.readfrom_rd   = 1'b0;
        ctrl.link          = 1'b0;
        ctrl.immcode       = IMMC_ZIMM5;
        ctrl.alu_op        = ALU_ADD;
        ctrl.alu_b_imm     = 1'b0;
        ctrl.fcu_op        = FCU_NONE;
        ctrl.wb_op         = WB_NONE;
        ctrl.err           = 1'b0;

        case (opcode)
            OP_NOP: begin
                ctrl.err = 1'b0; // bubble, nothing set
            end
            OP_ADDI: begin
                ctrl.immcode   = IMMC_SIMM5;
                ctrl.alu_b_imm = 1'b1;
                ctrl.wb_op     = WB_ALU;
            end
            OP_ANDNI: begin
                ctrl.alu_op    = ALU_ANDN; // zimm5 is the default code
                ctrl.alu_b_imm = 1'b1;
                ctrl.wb_op     = WB_ALU;
            end
            OP_RARITH: begin
                ctrl.instr_rformat = 1'b1;
                ctrl.wb_op         = WB_ALU;
                case (op_ext) // function extension only matters here
                    2'b00:   ctrl.alu_op = ALU_ADD;
                    2'b01:   ctrl.alu_op = ALU_SUB;
                    2'b10:   ctrl.alu_op = ALU_XOR;
                    default: ctrl.alu_op = ALU_ANDN;
                endcase
            end
            OP_LBI: begin
                ctrl.writeto_rs = 1'b1;
                ctrl.immcode    = IMMC_SIMM8;
                ctrl.alu_op     = ALU_PASSB;
                ctrl.alu_b_imm  = 1'b1;
                ctrl.wb_op      = WB_ALU;
            end
            OP_SLBI: begin
                ctrl.writeto_rs = 1'b1;
                ctrl.immcode    = IMMC_ZIMM8;
                ctrl.alu_op     = ALU_SLBI; // rs << 8 | imm
                ctrl.alu_b_imm  = 1'b1;
                ctrl.wb_op      = WB_ALU;
            end
            OP_LD: begin
                ctrl.immcode   = IMMC_SIMM5; // address = rs + simm5
                ctrl.alu_b_imm = 1'b1;
                ctrl.wb_op     = WB_MEM;
            end
            OP_ST: begin
                ctrl.readfrom_rd = 1'b1; // store data comes out on vy
                ctrl.immcode     = IMMC_SIMM5;
                ctrl.alu_b_imm   = 1'b1;
            end
            OP_BEQZ: begin
                ctrl.immcode = IMMC_SIMM8;
                ctrl.fcu_op  = FCU_BEQZ;
            end
            OP_BNEZ: begin
                ctrl.immcode = IMMC_SIMM8;
                ctrl.fcu_op  = FCU_BNEZ;
            end
            OP_J: begin
                ctrl.immcode = IMMC_DISPL;
                ctrl.fcu_op  = FCU_JUMP;
            end
            OP_JAL: begin
                ctrl.link    = 1'b1;
                ctrl.immcode = IMMC_DISPL;
                ctrl.fcu_op  = FCU_JUMP;
                ctrl.wb_op   = WB_PC; // return address into r7
            end
            OP_JR: begin
                ctrl.immcode = IMMC_SIMM8;
                ctrl.fcu_op  = FCU_JUMPR;
            end
            default: ctrl.err = 1'b1; // illegal, goes downstream as a bubble
        endcase
    end

endmodule

`default_nettype wire

// File: design/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::word_t    instr,
    input  isa_pkg::word_t    next_pc_basic, // from if/id
    input  logic              wb_rf_wen,     // writeback loopback from mem/wb
    input  isa_pkg::reg_idx_t wb_ro,
    input  isa_pkg::word_t    wb_data,
    decode_bundle_if.src      bundle
);
    import isa_pkg::*;

    decode_ctrl_if ctrl_bus ();

    // instruction fields
    opcode_t  opcode;
    op_ext_t  op_ext;
    reg_idx_t field_rs;
    reg_idx_t field_rt;      // r-format rt, same bits as i-format rd
    reg_idx_t field_rd_r;
    reg_idx_t field_rd_i;
    reg_idx_t rd_sel;        // rd picked by format
    reg_idx_t rx;
    reg_idx_t ry;
    reg_idx_t ro;
    word_t    imm16;
    word_t    vx;
    word_t    vy;

    assign opcode     = instr[15:11];
    assign op_ext     = instr[1:0];
    assign field_rs   = instr[10:8];
    assign field_rt   = instr[7:5];
    assign field_rd_r = instr[4:2];
    assign field_rd_i = instr[7:5];

    control u_control (
        .opcode (opcode),
        .op_ext (op_ext),
        .ctrl   (ctrl_bus.ctrl)
    );

    // register selects
    assign rd_sel = ctrl_bus.instr_rformat ? field_rd_r : field_rd_i;
    assign rx     = field_rs;
    assign ry     = ctrl_bus.readfrom_rd ? rd_sel : field_rt; // st reads rd on y
    assign ro     = ctrl_bus.link       ? LINK_REG :
                    ctrl_bus.writeto_rs ? field_rs : rd_sel;

    // immediate / displacement extension
    always_comb begin
        case (ctrl_bus.immcode)
            IMMC_ZIMM5: imm16 = {11'b0, instr[4:0]};
            IMMC_SIMM5: imm16 = {{11{instr[4]}}, instr[4:0]};
            IMMC_ZIMM8: imm16 = {8'b0, instr[7:0]};
            IMMC_SIMM8: imm16 = {{8{instr[7]}}, instr[7:0]};
            default:    imm16 = {{5{instr[10]}}, instr[10:0]}; // displ and unused codes
        endcase
    end

    rf_bypassed u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rf_wen   (wb_rf_wen),
        .wr_reg   (wb_ro),
        .wr_data  (wb_data),
        .rd1_reg  (rx),
        .rd1_data (vx),
        .rd2_reg  (ry),
        .rd2_data (vy)
    );

    // bundle toward id/ex
    assign bundle.alu_op    = ctrl_bus.alu_op;
    assign bundle.alu_b_imm = ctrl_bus.alu_b_imm;
    assign bundle.fcu_op    = ctrl_bus.fcu_op;
    assign bundle.wb_op     = ctrl_bus.wb_op;
    assign bundle.ro        = ro;
    assign bundle.vx        = vx;
    assign bundle.vy        = vy;
    assign bundle.imm16     = imm16;
    assign bundle.next_pc   = next_pc_basic; // used by jal writeback and branches
    assign bundle.err       = ctrl_bus.err;

endmodule

`default_nettype wire

// File: design/decode_bundle_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_bundle_if;
    import isa_pkg::*;

    alu_op_t  alu_op;
    logic     alu_b_imm;
    fcu_op_t  fcu_op;
    wb_op_t   wb_op;
    reg_idx_t ro;      // writeback register
    word_t    vx;      // rf value for rs
    word_t    vy;      // rf value for rt or rd
    word_t    imm16;   // extended imm or displacement
    word_t    next_pc; // pc + 2 from fetch
    logic     err;

    // decode side
    modport src (
        output alu_op, alu_b_imm, fcu_op, wb_op,
        output ro, vx, vy, imm16, next_pc, err
    );

    // id/ex register side
    modport dst (
        input alu_op, alu_b_imm, fcu_op, wb_op,
        input ro, vx, vy, imm16, next_pc, err
    );

endinterface

`default_nettype wire

// File: design/decode_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_ctrl_if;
    import isa_pkg::*;

    // register select controls
    logic      instr_rformat; // rd comes from instr[4:2] instead of instr[7:5]
    logic      writeto_rs;    // write back into rs
    logic      readfrom_rd;   // y port reads rd instead of rt
    logic      link;          // write back into r7
    imm_code_t immcode;

    // downstream controls
    alu_op_t   alu_op;
    logic      alu_b_imm;     // alu b from imm16 instead of vy
    fcu_op_t   fcu_op;
    wb_op_t    wb_op;
    logic      err;           // undefined opcode

    modport ctrl (
        output instr_rformat, writeto_rs, readfrom_rd, link, immcode,
        output alu_op, alu_b_imm, fcu_op, wb_op, err
    );

    modport dp (
        input instr_rformat, writeto_rs, readfrom_rd, link, immcode,
        input alu_op, alu_b_imm, fcu_op, wb_op, err
    );

endinterface

`default_nettype wire

// File: design/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::word_t    instr,
    input  isa_pkg::word_t    next_pc_basic,
    input  logic              stall,
    input  logic              flush,
    input  logic              wb_rf_wen,
    input  isa_pkg::reg_idx_t wb_ro,
    input  isa_pkg::word_t    wb_data,
    output isa_pkg::alu_op_t  ex_alu_op,
    output logic              ex_alu_b_imm,
    output isa_pkg::fcu_op_t  ex_fcu_op,
    output isa_pkg::wb_op_t   ex_wb_op,
    output isa_pkg::reg_idx_t ex_ro,
    output isa_pkg::word_t    ex_vx,
    output isa_pkg::word_t    ex_vy,
    output isa_pkg::word_t    ex_imm16,
    output isa_pkg::word_t    ex_next_pc,
    output logic              ex_err
);

    decode_bundle_if id_bus (); // decode -> id/ex

    decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (instr),
        .next_pc_basic (next_pc_basic),
        .wb_rf_wen     (wb_rf_wen),
        .wb_ro         (wb_ro),
        .wb_data       (wb_data),
        .bundle        (id_bus.src)
    );

    id_ex_reg u_id_ex_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .bundle       (id_bus.dst),
        .ex_alu_op    (ex_alu_op),
        .ex_alu_b_imm (ex_alu_b_imm),
        .ex_fcu_op    (ex_fcu_op),
        .ex_wb_op     (ex_wb_op),
        .ex_ro        (ex_ro),
        .ex_vx        (ex_vx),
        .ex_vy        (ex_vy),
        .ex_imm16     (ex_imm16),
        .ex_next_pc   (ex_next_pc),
        .ex_err       (ex_err)
    );

endmodule

`default_nettype wire

// File: design/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,  // hold current contents
    input  logic                 flush,  // load a bubble, beats stall
    decode_bundle_if.dst         bundle,
    output isa_pkg::alu_op_t     ex_alu_op,
    output logic                 ex_alu_b_imm,
    output isa_pkg::fcu_op_t     ex_fcu_op,
    output isa_pkg::wb_op_t      ex_wb_op,
    output isa_pkg::reg_idx_t    ex_ro,
    output isa_pkg::word_t       ex_vx,
    output isa_pkg::word_t       ex_vy,
    output isa_pkg::word_t       ex_imm16,
    output isa_pkg::word_t       ex_next_pc,
    output logic                 ex_err
);
    import isa_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_alu_op    <= ALU_ADD;
            ex_alu_b_imm <= 1'b0;
            ex_fcu_op    <= FCU_NONE;
            ex_wb_op     <= WB_NONE;
            ex_ro        <= '0;
            ex_vx        <= '0;
            ex_vy        <= '0;
            ex_imm16     <= '0;
            ex_next_pc   <= '0;
            ex_err       <= 1'b0;
        end else if (flush) begin
            // bubble is the same all-zero bundle as reset
            ex_alu_op    <= ALU_ADD;
            ex_alu_b_imm <= 1'b0;
            ex_fcu_op    <= FCU_NONE;
            ex_wb_op     <= WB_NONE;
            ex_ro        <= '0;
            ex_vx        <= '0;
            ex_vy        <= '0;
            ex_imm16     <= '0;
            ex_next_pc   <= '0;
            ex_err       <= 1'b0;
        end else if (!stall) begin
            ex_alu_op    <= bundle.alu_op;
            ex_alu_b_imm <= bundle.alu_b_imm;
            ex_fcu_op    <= bundle.fcu_op;
            ex_wb_op     <= bundle.wb_op;
            ex_ro        <= bundle.ro;
            ex_vx        <= bundle.vx;
            ex_vy        <= bundle.vy;
            ex_imm16     <= bundle.imm16;
            ex_next_pc   <= bundle.next_pc;
            ex_err       <= bundle.err;
        end
    end

endmodule

`default_nettype wire

// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // width types
    typedef logic [15:0] word_t;     // data word or pc
    typedef logic [2:0]  reg_idx_t;  // register number, r0..r7
    typedef logic [4:0]  opcode_t;   // instr[15:11]
    typedef logic [1:0]  op_ext_t;   // instr[1:0], function extension
    typedef logic [2:0]  imm_code_t; // immediate extension select
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  fcu_op_t;
    typedef logic [1:0]  wb_op_t;

    // immediate extension codes
    localparam imm_code_t IMMC_ZIMM5 = 3'd0; // instr[4:0] zero extended
    localparam imm_code_t IMMC_SIMM5 = 3'd1; // instr[4:0] sign extended
    localparam imm_code_t IMMC_ZIMM8 = 3'd2; // instr[7:0] zero extended
    localparam imm_code_t IMMC_SIMM8 = 3'd3; // instr[7:0] sign extended
    localparam imm_code_t IMMC_DISPL = 3'd4; // instr[10:0] sign extended

    // alu operations
    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_XOR   = 4'd2;
    localparam alu_op_t ALU_ANDN  = 4'd3;
    localparam alu_op_t ALU_PASSB = 4'd4;
    localparam alu_op_t ALU_SLBI  = 4'd5; // (a << 8) | b

    // flow control operations
    localparam fcu_op_t FCU_NONE  = 3'd0;
    localparam fcu_op_t FCU_BEQZ  = 3'd1;
    localparam fcu_op_t FCU_BNEZ  = 3'd2;
    localparam fcu_op_t FCU_JUMP  = 3'd3; // pc relative
    localparam fcu_op_t FCU_JUMPR = 3'd4; // register plus imm

    // writeback source
    localparam wb_op_t WB_NONE = 2'd0;
    localparam wb_op_t WB_ALU  = 2'd1;
    localparam wb_op_t WB_MEM  = 2'd2;
    localparam wb_op_t WB_PC   = 2'd3; // next sequential pc, for linking

    localparam reg_idx_t LINK_REG = 3'd7;

    // major opcodes
    localparam opcode_t OP_NOP    = 5'b00001;
    localparam opcode_t OP_J      = 5'b00100;
    localparam opcode_t OP_JR     = 5'b00101;
    localparam opcode_t OP_JAL    = 5'b00110;
    localparam opcode_t OP_ADDI   = 5'b01000;
    localparam opcode_t OP_ANDNI  = 5'b01011;
    localparam opcode_t OP_BEQZ   = 5'b01100;
    localparam opcode_t OP_BNEZ   = 5'b01101;
    localparam opcode_t OP_ST     = 5'b10000;
    localparam opcode_t OP_LD     = 5'b10001;
    localparam opcode_t OP_SLBI   = 5'b10010;
    localparam opcode_t OP_LBI    = 5'b11000;
    localparam opcode_t OP_RARITH = 5'b11011; // op_ext picks add/sub/xor/andn

endpackage

`default_nettype wire

// File: design/rf_bypassed.sv
`timescale 1ns/1ps
`default_nettype none

module rf_bypassed (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rf_wen,
    input  isa_pkg::reg_idx_t wr_reg,
    input  isa_pkg::word_t    wr_data,
    input  isa_pkg::reg_idx_t rd1_reg,
    output isa_pkg::word_t    rd1_data,
    input  isa_pkg::reg_idx_t rd2_reg,
    output isa_pkg::word_t    rd2_data
);
    import isa_pkg::*;

    word_t regs [8]; // r0 is an ordinary register here

    logic hit1; // port 1 reads the register being written
    logic hit2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wen) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // write-through so a same-cycle writeback is seen by decode
    assign hit1 = rf_wen && (wr_reg == rd1_reg);
    assign hit2 = rf_wen && (wr_reg == rd2_reg);

    assign rd1_data = hit1 ? wr_data : regs[rd1_reg];
    assign rd2_data = hit2 ? wr_data : regs[rd2_reg];

endmodule

`default_nettype wire

// File: filelist.f
design/isa_pkg.sv
design/decode_ctrl_if.sv
design/decode_bundle_if.sv
design/control.sv
design/rf_bypassed.sv
design/decode.sv
design/id_ex_reg.sv
design/decode_top.sv
verification/decode_asserts.sv
verification/decode_tb.sv

// File: verification/decode_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module decode_asserts (
    input logic              clk,
    input logic              rst_n,
    input logic              stall,
    input logic              flush,
    input isa_pkg::alu_op_t  ex_alu_op,
    input logic              ex_alu_b_imm,
    input isa_pkg::fcu_op_t  ex_fcu_op,
    input isa_pkg::wb_op_t   ex_wb_op,
    input isa_pkg::reg_idx_t ex_ro,
    input isa_pkg::word_t    ex_vx,
    input isa_pkg::word_t    ex_vy,
    input isa_pkg::word_t    ex_imm16,
    input isa_pkg::word_t    ex_next_pc,
    input logic              ex_err
);
    import isa_pkg::*;

    logic [77:0] ex_all; // every ex_ output side by side

    assign ex_all = {ex_alu_op, ex_alu_b_imm, ex_fcu_op, ex_wb_op, ex_ro,
                     ex_vx, ex_vy, ex_imm16, ex_next_pc, ex_err};

    // bubble one cycle after flush, stall or not
    a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (ex_all == '0))
        else $error("flush did not leave an all-zero id/ex register");

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !flush) |=> $stable(ex_all))
        else $error("id/ex register changed under stall");

    // illegal opcode travels as a bubble with the flag set
    a_err_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        ex_err |-> (ex_alu_op == '0 && ex_fcu_op == '0 && ex_wb_op == '0))
        else $error("ex_err with nonzero controls");

    a_reset_zero: assert property (@(posedge clk)
        !rst_n |-> (ex_all == '0))
        else $error("ex_ outputs not zero during reset");

endmodule

bind decode_top decode_asserts u_asserts (.*);

`default_nettype wire

// File: verification/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb;
    import isa_pkg::*;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     alu_b_imm;
        fcu_op_t  fcu_op;
        wb_op_t   wb_op;
        reg_idx_t ro;
        word_t    vx;
        word_t    vy;
        word_t    imm16;
        word_t    next_pc;
        logic     err;
    } exp_t;

    logic     clk;
    logic     rst_n;
    word_t    instr;
    word_t    next_pc_basic;
    logic     stall;
    logic     flush;
    logic     wb_rf_wen;
    reg_idx_t wb_ro;
    word_t    wb_data;
    alu_op_t  ex_alu_op;
    logic     ex_alu_b_imm;
    fcu_op_t  ex_fcu_op;
    wb_op_t   ex_wb_op;
    reg_idx_t ex_ro;
    word_t    ex_vx;
    word_t    ex_vy;
    word_t    ex_imm16;
    word_t    ex_next_pc;
    logic     ex_err;

    word_t       shadow [8];  // tb copy of the register file
    exp_t        exp_q [$];   // expectations waiting for the comparator
    logic [31:0] lcg_state;
    int          n_checks;
    int          n_errors;
    int          err_mark;    // error count at start of current test

    decode_top dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic word_t next_rand();
        lcg_state = lcg_step(lcg_state);
        return lcg_state[31:16]; // upper bits have the longer period
    endfunction

    // expected id/ex contents for one instruction, straight from the opcode table
    function automatic exp_t decode_ref(input word_t w, input word_t npc);
        exp_t      e;
        reg_idx_t  ry;
        imm_code_t ic;
        alu_op_t   rar_ops [4];
        rar_ops = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN};
        e = '0;
        e.ro = w[7:5];        // i-format rd
        e.next_pc = npc;
        ry = w[7:5];          // rt
        ic = IMMC_ZIMM5;
        case (w[15:11])
            OP_NOP: ;
            OP_ADDI, OP_LD: begin
                ic = IMMC_SIMM5;
                e.alu_b_imm = 1'b1;
                e.wb_op = (w[15:11] == OP_LD) ? WB_MEM : WB_ALU;
            end
            OP_ANDNI: begin
                e.alu_op = ALU_ANDN;
                e.alu_b_imm = 1'b1;
                e.wb_op = WB_ALU;
            end
            OP_RARITH: begin
                e.ro = w[4:2];
                e.alu_op = rar_ops[w[1:0]];
                e.wb_op = WB_ALU;
            end
            OP_LBI, OP_SLBI: begin
                e.ro = w[10:8];   // writes rs
                ic = (w[15:11] == OP_LBI) ? IMMC_SIMM8 : IMMC_ZIMM8;
                e.alu_op = (w[15:11] == OP_LBI) ? ALU_PASSB : ALU_SLBI;
                e.alu_b_imm = 1'b1;
                e.wb_op = WB_ALU;
            end
            OP_ST: begin
                ic = IMMC_SIMM5;
                ry = w[7:5];      // store data is the i-format rd
                e.alu_b_imm = 1'b1;
            end
            OP_BEQZ: begin
                ic = IMMC_SIMM8;
                e.fcu_op = FCU_BEQZ;
            end
            OP_BNEZ: begin
                ic = IMMC_SIMM8;
                e.fcu_op = FCU_BNEZ;
            end
            OP_J, OP_JAL: begin
                ic = IMMC_DISPL;
                e.fcu_op = FCU_JUMP;
                if (w[15:11] == OP_JAL) begin
                    e.ro = LINK_REG;
                    e.wb_op = WB_PC;
                end
            end
            OP_JR: begin
                ic = IMMC_SIMM8;
                e.fcu_op = FCU_JUMPR;
            end
            default: e.err = 1'b1;
        endcase
        e.vx = shadow[w[10:8]];
        e.vy = shadow[ry];
        case (ic)
            IMMC_ZIMM5: e.imm16 = 16'(w[4:0]);
            IMMC_SIMM5: e.imm16 = 16'($signed(w[4:0]));
            IMMC_ZIMM8: e.imm16 = 16'(w[7:0]);
            IMMC_SIMM8: e.imm16 = 16'($signed(w[7:0]));
            default:    e.imm16 = 16'($signed(w[10:0]));
        endcase
        return e;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_fcu_op(input string name, input fcu_op_t exp, input fcu_op_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_wb_op(input string name, input wb_op_t exp, input wb_op_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // outputs settle after the rising edge, so compare in the low phase
    always @(negedge clk) begin : compare
        exp_t e;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_alu_op("ex_alu_op", e.alu_op, ex_alu_op);
            check_bit("ex_alu_b_imm", e.alu_b_imm, ex_alu_b_imm);
            check_fcu_op("ex_fcu_op", e.fcu_op, ex_fcu_op);
            check_wb_op("ex_wb_op", e.wb_op, ex_wb_op);
            check_reg_idx("ex_ro", e.ro, ex_ro);
            check_word("ex_vx", e.vx, ex_vx);
            check_word("ex_vy", e.vy, ex_vy);
            check_word("ex_imm16", e.imm16, ex_imm16);
            check_word("ex_next_pc", e.next_pc, ex_next_pc);
            check_bit("ex_err", e.err, ex_err);
        end
    end

    // one instruction into decode, optionally with a writeback in the same cycle
    task automatic send(input word_t w, input word_t pc, input logic wen,
                        input reg_idx_t wr, input word_t wd);
        exp_t e;
        @(posedge clk);
        instr <= w;
        next_pc_basic <= pc;
        wb_rf_wen <= wen;
        wb_ro <= wr;
        wb_data <= wd;
        if (wen) begin
            shadow[wr] = wd; // bypass makes it visible right away
        end
        e = decode_ref(w, pc);
        @(posedge clk);      // id/ex captures here
        wb_rf_wen <= 1'b0;
        exp_q.push_back(e);
    endtask

    task automatic end_test(input string name);
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            n_errors++;
            $display("timeout: comparator still has %0d results pending in %s",
                     exp_q.size(), name);
            exp_q.delete();
        end
        $display("test %-16s done, %0d errors", name, n_errors - err_mark);
        err_mark = n_errors;
    endtask

    initial begin : stimulus
        word_t w;
        word_t pc;
        exp_t  ea;
        int    n_jal;
        int    n_ill;
        clk = 1'b0;
        rst_n = 1'b0;
        instr = 16'hffff;       // undefined opcode, must not leak out of reset
        next_pc_basic = 16'h1234;
        stall = 1'b1;           // keep the reset contents while checking them
        flush = 1'b0;
        wb_rf_wen = 1'b0;
        wb_ro = '0;
        wb_data = '0;
        lcg_state = 32'd4;
        n_checks = 0;
        n_errors = 0;
        err_mark = 0;
        n_jal = 0;
        n_ill = 0;
        for (int i = 0; i < 8; i++) begin
            shadow[i] = '0;
        end

        // 1: reset
        repeat (15) @(posedge clk);
        exp_q.push_back('0);    // still in reset
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            exp_q.push_back('0);
        end
        @(posedge clk);
        stall <= 1'b0;
        end_test("reset");

        // 2: fill all registers, then read every rs/rt pair
        for (int r = 0; r < 8; r++) begin
            send({OP_NOP, 11'd0}, 16'h0100, 1'b1, reg_idx_t'(r), next_rand());
        end
        for (int rs = 0; rs < 8; rs++) begin
            for (int rt = 0; rt < 8; rt++) begin
                w = next_rand();
                send({OP_RARITH, 3'(rs), 3'(rt), w[4:0]}, 16'h0200, 1'b0, '0, '0);
            end
        end
        end_test("writeback/read");

        // 3: same-cycle write and read, on x then y
        send({OP_RARITH, 3'd3, 3'd5, 5'd0}, 16'h0300, 1'b1, 3'd3, 16'hbeef);
        send({OP_RARITH, 3'd6, 3'd3, 5'd1}, 16'h0302, 1'b1, 3'd3, 16'h5a5a);
        send({OP_RARITH, 3'd3, 3'd2, 5'd2}, 16'h0304, 1'b0, '0, '0);
        end_test("bypass");

        // 4: random words, undefined opcodes included
        for (int i = 0; i < 200; i++) begin
            w = next_rand();
            pc = next_rand() & 16'hfffe;
            ea = decode_ref(w, pc);
            if (ea.err) n_ill++;
            if (w[15:11] == OP_JAL) n_jal++;
            send(w, pc, 1'b0, '0, '0);
        end
        if (n_ill == 0 || n_jal == 0) begin
            n_errors++;
            $display("random words missed a case: %0d illegal and %0d jal seen",
                     n_ill, n_jal);
        end
        end_test("random decode");

        // 5: stall holds, flush bubbles, flush beats stall
        w = {OP_ADDI, 3'd1, 3'd2, 5'b10011};
        send(w, 16'h0400, 1'b0, '0, '0);
        ea = decode_ref(w, 16'h0400);
        @(posedge clk);
        stall <= 1'b1;
        instr <= next_rand();
        repeat (3) begin
            @(posedge clk);
            instr <= next_rand();  // decode keeps moving underneath
            exp_q.push_back(ea);
        end
        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b1;
        exp_q.push_back(ea);       // this edge still saw stall only
        @(posedge clk);
        stall <= 1'b1;
        exp_q.push_back('0);       // flush alone
        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b0;
        exp_q.push_back('0);       // flush and stall together
        send({OP_JAL, 11'h7f0}, 16'h0500, 1'b0, '0, '0);
        end_test("pipeline control");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
